/* design/rv32i_types.sv */
package rv32i_types;

    typedef logic [31:0] rv32i_word;

    // selector states for one chooser row in order from local toward global.
    typedef enum logic [1:0] {
        strong_local,
        weak_local,
        weak_global,
        strong_global
    } chooser_t;

    // two-bit saturating counter whose upper bit is the taken prediction.
    typedef enum logic [1:0] {
        strong_nt,
        weak_nt,
        weak_t,
        strong_t
    } ctr_t;

    function automatic logic ctr_taken(ctr_t c);
        logic [1:0] bits;
        bits = c;
        return bits[1];
    endfunction

    // one step of saturation toward the resolved outcome.
    function automatic ctr_t ctr_next(ctr_t c, logic taken);
        ctr_t n;
        n = c;
        case (c)
            strong_nt: n = taken ? weak_nt : strong_nt;
            weak_nt:   n = taken ? weak_t : strong_nt;
            weak_t:    n = taken ? strong_t : weak_nt;
            strong_t:  n = taken ? strong_t : weak_t;
            default:   n = c;
        endcase
        return n;
    endfunction

endpackage : rv32i_types

/* design/bp_update_if.sv */
`timescale 1ns/1ps

interface bp_update_if;
    import rv32i_types::*;

    logic      update; // single-cycle strobe from execute.
    logic      br_en;  // resolved outcome of the branch at waddr.
    rv32i_word raddr;  // fetch address, looked up every cycle.
    rv32i_word waddr;

    modport host (
        output update,
        output br_en,
        output raddr,
        output waddr
    );

    modport predictor (
        input update,
        input br_en,
        input raddr,
        input waddr
    );

endinterface : bp_update_if

/* design/gbht.sv */
`timescale 1ns/1ps

module gbht #(
    parameter int s_row_idx   = 5,
    parameter int s_pc_offset = 2,
    parameter int ghist_bits  = 5
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   update,
    input  logic                   br_en,
    input  rv32i_types::rv32i_word raddr,
    input  rv32i_types::rv32i_word waddr,
    output logic                   br_take,
    output logic                   mispred
);
    import rv32i_types::*;

    localparam int s_row = 2**s_row_idx;

    ctr_t                  ctr_table [s_row];
    logic [ghist_bits-1:0] ghist;
    logic [s_row_idx-1:0]  r_row;
    logic [s_row_idx-1:0]  w_row;
    ctr_t                  r_ctr;
    ctr_t                  w_ctr;

    // the history is folded into the low end of the address index.
    assign r_row = raddr[s_row_idx+s_pc_offset-1:s_pc_offset] ^ s_row_idx'(ghist);
    assign w_row = waddr[s_row_idx+s_pc_offset-1:s_pc_offset] ^ s_row_idx'(ghist);

    assign r_ctr = ctr_table[r_row];
    assign w_ctr = ctr_table[w_row];

    assign br_take = ctr_taken(r_ctr);
    assign mispred = ctr_taken(w_ctr) != br_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < s_row; i++) begin
                ctr_table[i] <= weak_nt;
            end
        end else if (update) begin
            ctr_table[w_row] <= ctr_next(w_ctr, br_en);
        end
    end

    // newest outcome enters at bit zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            ghist <= '0;
        end else if (update) begin
            ghist <= {ghist[ghist_bits-2:0], br_en};
        end
    end

endmodule : gbht

/* design/lbht.sv */
`timescale 1ns/1ps

module lbht #(
    parameter int s_pc_offset = 2,
    parameter int lhist_idx   = 4,
    parameter int lhist_bits  = 5
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   update,
    input  logic                   br_en,
    input  rv32i_types::rv32i_word raddr,
    input  rv32i_types::rv32i_word waddr,
    output logic                   br_take,
    output logic                   mispred
);
    import rv32i_types::*;

    localparam int s_hist = 2**lhist_idx;
    localparam int s_ctr  = 2**lhist_bits;

    logic [lhist_bits-1:0] hist_table [s_hist];
    ctr_t                  ctr_table [s_ctr];
    logic [lhist_idx-1:0]  r_idx;
    logic [lhist_idx-1:0]  w_idx;
    logic [lhist_bits-1:0] r_hist;
    logic [lhist_bits-1:0] w_hist;
    ctr_t                  r_ctr;
    ctr_t                  w_ctr;

    assign r_idx = raddr[lhist_idx+s_pc_offset-1:s_pc_offset];
    assign w_idx = waddr[lhist_idx+s_pc_offset-1:s_pc_offset];

    assign r_hist = hist_table[r_idx];
    assign w_hist = hist_table[w_idx];

    // each branch's own pattern picks the counter, not its address.
    assign r_ctr = ctr_table[r_hist];
    assign w_ctr = ctr_table[w_hist];

    assign br_take = ctr_taken(r_ctr);
    assign mispred = ctr_taken(w_ctr) != br_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < s_hist; i++) begin
                hist_table[i] <= '0;
            end
        end else if (update) begin
            hist_table[w_idx] <= {w_hist[lhist_bits-2:0], br_en};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < s_ctr; i++) begin
                ctr_table[i] <= weak_nt;
            end
        end else if (update) begin
            ctr_table[w_hist] <= ctr_next(w_ctr, br_en);
        end
    end

endmodule : lbht

/* design/tournament_p.sv */
`timescale 1ns/1ps

module tournament_p #(
    parameter int s_row_idx   = 5,
    parameter int s_pc_offset = 2,
    parameter int ghist_bits  = 5,
    parameter int lhist_idx   = 4,
    parameter int lhist_bits  = 5
) (
    input  logic                  clk,
    input  logic                  rst,
    bp_update_if.predictor        bus,
    output logic                  br_take,
    output logic                  mispred
);
    import rv32i_types::*;

    localparam int s_row = 2**s_row_idx;

    chooser_t             sel_table [s_row];
    logic [s_row_idx-1:0] r_row;
    logic [s_row_idx-1:0] w_row;
    chooser_t             r_state;
    chooser_t             w_state;
    chooser_t             next_state;
    logic                 g_br_take;
    logic                 l_br_take;
    logic                 g_mispred;
    logic                 l_mispred;

    gbht #(
        .s_row_idx  (s_row_idx),
        .s_pc_offset(s_pc_offset),
        .ghist_bits (ghist_bits)
    ) u_gbht (
        .clk    (clk),
        .rst    (rst),
        .update (bus.update),
        .br_en  (bus.br_en),
        .raddr  (bus.raddr),
        .waddr  (bus.waddr),
        .br_take(g_br_take),
        .mispred(g_mispred)
    );

    lbht #(
        .s_pc_offset(s_pc_offset),
        .lhist_idx  (lhist_idx),
        .lhist_bits (lhist_bits)
    ) u_lbht (
        .clk    (clk),
        .rst    (rst),
        .update (bus.update),
        .br_en  (bus.br_en),
        .raddr  (bus.raddr),
        .waddr  (bus.waddr),
        .br_take(l_br_take),
        .mispred(l_mispred)
    );

    assign r_row = bus.raddr[s_row_idx+s_pc_offset-1:s_pc_offset];
    assign w_row = bus.waddr[s_row_idx+s_pc_offset-1:s_pc_offset];

    assign w_state = sel_table[w_row];
    // a read of the row being trained sees the value it is about to get.
    assign r_state = (bus.update && (r_row == w_row)) ? next_state : sel_table[r_row];

    assign br_take = (r_state inside {strong_local, weak_local}) ? l_br_take : g_br_take;
    assign mispred = (w_state inside {strong_local, weak_local}) ? l_mispred : g_mispred;

    // move one step toward whichever side got it right, only when they disagree.
    always_comb begin
        next_state = w_state;
        if (bus.update && (l_mispred != g_mispred)) begin
            case (w_state)
                strong_local:  next_state = l_mispred ? weak_local : strong_local;
                weak_local:    next_state = l_mispred ? weak_global : strong_local;
                weak_global:   next_state = g_mispred ? weak_local : strong_global;
                strong_global: next_state = g_mispred ? weak_global : strong_global;
                default:       next_state = w_state;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < s_row; i++) begin
                sel_table[i] <= weak_local;
            end
        end else if (bus.update) begin
            sel_table[w_row] <= next_state;
        end
    end

endmodule : tournament_p

/* design/branch_predictor_top.sv */
`timescale 1ns/1ps

module branch_predictor_top #(
    parameter int s_row_idx   = 5,
    parameter int s_pc_offset = 2,
    parameter int ghist_bits  = 5,
    parameter int lhist_idx   = 4,
    parameter int lhist_bits  = 5
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   update,
    input  logic                   br_en,
    input  rv32i_types::rv32i_word raddr,
    input  rv32i_types::rv32i_word waddr,
    output logic                   br_take,
    output logic                   mispred
);

    bp_update_if bus ();

    // fetch and execute both land on the one bundle.
    assign bus.update = update;
    assign bus.br_en  = br_en;
    assign bus.raddr  = raddr;
    assign bus.waddr  = waddr;

    tournament_p #(
        .s_row_idx  (s_row_idx),
        .s_pc_offset(s_pc_offset),
        .ghist_bits (ghist_bits),
        .lhist_idx  (lhist_idx),
        .lhist_bits (lhist_bits)
    ) u_tournament (
        .clk    (clk),
        .rst    (rst),
        .bus    (bus.predictor),
        .br_take(br_take),
        .mispred(mispred)
    );

endmodule : branch_predictor_top

/* sim/bp_model.svh */
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

// reference tables sized for the default top-level parameters.
// 32 chooser rows, 32 global counters, 16 local histories of 5 bits.
logic [4:0] ref_ghist;
logic [1:0] ref_gctr [32];
logic [4:0] ref_lhist [16];
logic [1:0] ref_lctr [32];
logic [1:0] ref_sel [32]; // 0 and 1 lean local, 2 and 3 lean global.

// one saturating step up or down for counters and chooser rows alike.
function automatic logic [1:0] sat_step(input logic [1:0] c, input logic up);
    if (up) begin
        return (c == 2'd3) ? c : c + 2'd1;
    end
    return (c == 2'd0) ? c : c - 2'd1;
endfunction

task automatic reset_model();
    ref_ghist = 5'd0;
    for (int i = 0; i < 32; i++) begin
        ref_gctr[i] = 2'd1; // weakly not taken.
        ref_lctr[i] = 2'd1;
        ref_sel[i]  = 2'd1; // weakly local.
    end
    for (int i = 0; i < 16; i++) begin
        ref_lhist[i] = 5'd0;
    end
endtask

// returns the outputs for the current state, then trains when upd is high.
task automatic predict_and_train(input logic upd, input logic en, input logic [31:0] ra,
                                 input logic [31:0] wa, output logic take,
                                 output logic miss);
    logic [4:0] g_r;
    logic [4:0] g_w;
    logic [4:0] l_rh;
    logic [4:0] l_wh;
    logic       g_miss;
    logic       l_miss;
    logic [1:0] w_sel;
    logic [1:0] r_sel;
    logic [1:0] sel_next;
    g_r    = ra[6:2] ^ ref_ghist;
    g_w    = wa[6:2] ^ ref_ghist;
    l_rh   = ref_lhist[ra[5:2]];
    l_wh   = ref_lhist[wa[5:2]];
    g_miss = ref_gctr[g_w][1] != en;
    l_miss = ref_lctr[l_wh][1] != en;
    w_sel  = ref_sel[wa[6:2]];
    // a local miss pushes the row toward global, a global miss toward local.
    sel_next = (upd && (g_miss != l_miss)) ? sat_step(w_sel, l_miss) : w_sel;
    r_sel    = (upd && (ra[6:2] == wa[6:2])) ? sel_next : ref_sel[ra[6:2]];
    take = r_sel[1] ? ref_gctr[g_r][1] : ref_lctr[l_rh][1];
    miss = w_sel[1] ? g_miss : l_miss;
    if (upd) begin
        ref_gctr[g_w]      = sat_step(ref_gctr[g_w], en);
        ref_ghist          = {ref_ghist[3:0], en};
        ref_lctr[l_wh]     = sat_step(ref_lctr[l_wh], en);
        ref_lhist[wa[5:2]] = {l_wh[3:0], en};
        ref_sel[wa[6:2]]   = sel_next;
    end
endtask

`endif

/* sim/tb_branch_predictor.sv */
`timescale 1ns/1ps

module tb_branch_predictor;
    import rv32i_types::*;

    typedef struct packed {
        logic      update;
        logic      br_en;
        rv32i_word raddr;
        rv32i_word waddr;
        logic      exp_take;
        logic      exp_mispred;
    } row_t;

    logic      clk;
    logic      rst;
    logic      update;
    logic      br_en;
    rv32i_word raddr;
    rv32i_word waddr;
    logic      br_take;
    logic      mispred;

    row_t      rows [$];
    row_t      cur;
    logic      t_exp;
    logic      m_exp;
    int        seed;
    int        errors;
    int        cycles;
    int        limit;

    `include "bp_model.svh"

    branch_predictor_top DUT (
        .clk    (clk),
        .rst    (rst),
        .update (update),
        .br_en  (br_en),
        .raddr  (raddr),
        .waddr  (waddr),
        .br_take(br_take),
        .mispred(mispred)
    );

    always #2 clk = ~clk;

    task automatic add_row(input logic upd, input logic en, input rv32i_word ra,
                           input rv32i_word wa);
        row_t r;
        r        = '0;
        r.update = upd;
        r.br_en  = en;
        r.raddr  = ra;
        r.waddr  = wa;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [15:0] pattern;
        rv32i_word   a;
        rv32i_word   b;
        int          r;
        pattern = 16'hb2c5;
        for (int i = 0; i < 6; i++) begin
            add_row(1'b0, 1'b0, 32'h1000 + 28 * i, 32'h0); // reads only on fresh tables.
        end
        for (int i = 0; i < 4; i++) begin
            add_row(1'b1, i[0], 32'h40 + 8 * i, 32'h80 + 12 * i);
        end
        for (int i = 0; i < 10; i++) begin
            add_row(1'b1, 1'b1, 32'h100, 32'h100); // always taken.
        end
        for (int i = 0; i < 24; i++) begin
            add_row(1'b1, i[0], 32'h204, 32'h204); // alternating branch.
        end
        // the second branch repeats the first one's outcome.
        for (int i = 0; i < 32; i++) begin
            add_row(1'b1, pattern[i % 16], 32'h344, 32'h300);
            add_row(1'b1, pattern[i % 16], 32'h300, 32'h344);
        end
        // the first not-taken update here moves a fresh chooser row over to global.
        for (int i = 0; i < 6; i++) begin
            add_row(1'b1, i >= 3, 32'h3c8 + 32'h80, 32'h3c8);
        end
        for (int i = 0; i < 200; i++) begin
            a = $random(seed) & 32'h0000_01fc;
            b = $random(seed) & 32'h0000_01fc;
            r = $random(seed);
            add_row(r[1:0] != 2'b00, r[2], a, b);
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout, the run did not finish within %0d cycles", limit);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        clk    = 1'b0;
        rst    = 1'b1;
        update = 1'b0;
        br_en  = 1'b0;
        raddr  = '0;
        waddr  = '0;
        errors = 0;
        cycles = 0;
        seed   = 32'h7a16_c5a9;
        build_table();
        limit = rows.size() + 50;
        reset_model();
        foreach (rows[i]) begin
            cur = rows[i];
            predict_and_train(cur.update, cur.br_en, cur.raddr, cur.waddr, t_exp, m_exp);
            cur.exp_take    = t_exp;
            cur.exp_mispred = m_exp;
            rows[i]         = cur;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (rows[i]) begin
            cur = rows[i];
            @(negedge clk);
            update = cur.update;
            br_en  = cur.br_en;
            raddr  = cur.raddr;
            waddr  = cur.waddr;
            #1; // outputs settle well before the rising edge.
            if (br_take !== cur.exp_take) begin
                $display("ERROR br_take row %0d: expected %h, got %h", i, cur.exp_take, br_take);
                errors++;
            end
            if (cur.update && (mispred !== cur.exp_mispred)) begin
                $display("ERROR mispred row %0d: expected %h, got %h", i, cur.exp_mispred,
                         mispred);
                errors++;
            end
        end
        @(negedge clk);
        update = 1'b0;
        $display("%0d errors over %0d rows", errors, rows.size());
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_branch_predictor

/* sim.f */
+incdir+sim
design/rv32i_types.sv
design/bp_update_if.sv
design/gbht.sv
design/lbht.sv
design/tournament_p.sv
design/branch_predictor_top.sv
sim/tb_branch_predictor.sv
